// ==== src.f ====
+incdir+verif
design/ara_pkg.sv
design/lane_vrf.sv
design/lane.sv
design/ara_dispatcher.sv
design/ara_sequencer.sv
design/ara.sv
verif/tb_ara.sv

// ==== Bender.yml ====
package:
  name: ara_lite

sources:
  - files:
      - design/ara_pkg.sv
      - design/lane_vrf.sv
      - design/lane.sv
      - design/ara_dispatcher.sv
      - design/ara_sequencer.sv
      - design/ara.sv

  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_ara.sv

// ==== verif/tb_ara_model.svh ====
// Vector coprocessor reference model
`ifndef TB_ARA_MODEL_SVH
`define TB_ARA_MODEL_SVH

// Register file as the host sees it, element i at [reg][i]
elen_t model_vrf [NR_VREGS][VLMAX];

// Expected responses in request order
elen_t exp_data_q [$];
logic  exp_error_q [$];

task automatic model_reset();
  for (int r = 0; r < NR_VREGS; r++) begin
    for (int i = 0; i < VLMAX; i++) begin
      model_vrf[r][i] = '0;
    end
  end
  exp_data_q.delete();
  exp_error_q.delete();
endtask

// One element of an element-wise op, vs2 on the left
function automatic elen_t element_result(vec_op_e op, elen_t vs2_elem, elen_t vs1_elem,
                                         elen_t scalar);
  case (op)
    OP_VADD:    return vs2_elem + vs1_elem;
    OP_VSUB:    return vs2_elem - vs1_elem;
    OP_VAND:    return vs2_elem & vs1_elem;
    OP_VOR:     return vs2_elem | vs1_elem;
    OP_VXOR:    return vs2_elem ^ vs1_elem;
    OP_VADD_VX: return vs2_elem + scalar;
    OP_VMV_VX:  return scalar;
    default:    return '0;
  endcase
endfunction

// Apply one accepted request and queue its response
task automatic model_apply(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2,
                           elen_t scalar, vlen_t vl);
  elen_t data;
  logic  error;
  data  = '0;
  error = 1'b0;
  if (op == OP_VEXT_XV) begin
    if (scalar < VLMAX) begin
      data = model_vrf[vs2][int'(scalar)];
    end
  end else if (vl > VLMAX) begin
    error = 1'b1;
  end else begin
    // Tail elements at or above vl stay as they are
    for (int i = 0; i < vl; i++) begin
      model_vrf[vd][i] = element_result(op, model_vrf[vs2][i], model_vrf[vs1][i], scalar);
    end
  end
  exp_data_q.push_back(data);
  exp_error_q.push_back(error);
endtask

`endif

// ==== verif/tb_ara.sv ====
// Vector coprocessor testbench
module tb_ara import ara_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED = 7791;
  localparam int unsigned N_OPS = 400;
  localparam int unsigned N_RESET_OPS = NR_VREGS * VLMAX;
  // Longer than the longest stall of resp_ready_i
  localparam int unsigned DRAIN_CYCLES = 100;
  localparam int unsigned TIMEOUT_CYCLES = (N_OPS + N_RESET_OPS) * 64 + DRAIN_CYCLES;

  logic      clk_i;
  logic      reset_i;
  logic      req_valid_i;
  logic      req_ready_o;
  vec_op_e   req_op_i;
  vreg_idx_t req_vd_i;
  vreg_idx_t req_vs1_i;
  vreg_idx_t req_vs2_i;
  elen_t     req_scalar_i;
  vlen_t     req_vl_i;
  logic      resp_valid_o;
  logic      resp_ready_i;
  elen_t     resp_data_o;
  logic      resp_error_o;

  int unsigned req_count;
  int unsigned resp_count;

  `include "tb_ara_model.svh"

  ara i_dut (
    .clk_i       (clk_i       ),
    .reset_i     (reset_i     ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_op_i    (req_op_i    ),
    .req_vd_i    (req_vd_i    ),
    .req_vs1_i   (req_vs1_i   ),
    .req_vs2_i   (req_vs2_i   ),
    .req_scalar_i(req_scalar_i),
    .req_vl_i    (req_vl_i    ),
    .resp_valid_o(resp_valid_o),
    .resp_ready_i(resp_ready_i),
    .resp_data_o (resp_data_o ),
    .resp_error_o(resp_error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Starts on a rising edge and returns on the handshake edge
  task automatic send_request(vec_op_e op, vreg_idx_t vd, vreg_idx_t vs1, vreg_idx_t vs2,
                              elen_t scalar, vlen_t vl);
    req_valid_i  <= 1'b1;
    req_op_i     <= op;
    req_vd_i     <= vd;
    req_vs1_i    <= vs1;
    req_vs2_i    <= vs2;
    req_scalar_i <= scalar;
    req_vl_i     <= vl;
    @(posedge clk_i);
    while (!req_ready_o) begin
      @(posedge clk_i);
    end
    req_valid_i <= 1'b0;
  endtask

  // Mostly legal, some zero and some above VLMAX
  function automatic vlen_t pick_vl();
    int unsigned r;
    r = $urandom_range(0, 9);
    if (r == 0) begin
      return '0;
    end else if (r == 1) begin
      return vlen_t'($urandom_range(VLMAX + 1, (1 << VL_W) - 1));
    end
    return vlen_t'($urandom_range(1, VLMAX));
  endfunction

  function automatic elen_t pick_index();
    int unsigned r;
    r = $urandom_range(0, 9);
    if (r == 0) begin
      return elen_t'($urandom_range(VLMAX, VLMAX + 3));
    end else if (r == 1) begin
      return elen_t'($urandom());
    end
    return elen_t'($urandom_range(0, VLMAX - 1));
  endfunction

  task automatic toggle_resp_ready();
    int unsigned len;
    forever begin
      // One stretch in four is a long stall
      len = ($urandom_range(0, 3) == 0) ? $urandom_range(20, 60) : $urandom_range(1, 4);
      resp_ready_i <= 1'b0;
      repeat (len) @(posedge clk_i);
      resp_ready_i <= 1'b1;
      repeat ($urandom_range(1, 12)) @(posedge clk_i);
    end
  endtask

  task automatic run_reset_sweep();
    for (int r = 0; r < NR_VREGS; r++) begin
      for (int i = 0; i < VLMAX; i++) begin
        send_request(OP_VEXT_XV, '0, '0, vreg_idx_t'(r), elen_t'(i), '0);
      end
    end
  endtask

  // Each op is followed by a few extracts from its destination
  task automatic run_random_ops();
    int unsigned sent;
    int unsigned n_ext;
    vreg_idx_t   vd;
    sent = 0;
    while (sent < N_OPS) begin
      vd = vreg_idx_t'($urandom_range(0, NR_VREGS - 1));
      send_request(vec_op_e'($urandom_range(0, 6)), vd,
                   vreg_idx_t'($urandom_range(0, NR_VREGS - 1)),
                   vreg_idx_t'($urandom_range(0, NR_VREGS - 1)),
                   elen_t'($urandom()), pick_vl());
      sent++;
      n_ext = $urandom_range(1, 3);
      for (int e = 0; e < n_ext; e++) begin
        send_request(OP_VEXT_XV, '0, '0, vd, pick_index(), vlen_t'($urandom()));
        sent++;
      end
      repeat ($urandom_range(0, 3)) @(posedge clk_i);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and checks
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (resp_valid_o && resp_ready_i) begin
        if (exp_data_q.size() == 0) begin
          abort_run("A response arrived while no request was outstanding");
        end else begin
          check_value("resp_data_o", exp_data_q.pop_front(), resp_data_o);
          check_value("resp_error_o", 32'(exp_error_q.pop_front()), 32'(resp_error_o));
          resp_count++;
        end
      end
      if (req_valid_i && req_ready_o) begin
        model_apply(req_op_i, req_vd_i, req_vs1_i, req_vs2_i, req_scalar_i, req_vl_i);
        req_count++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    abort_run("Timeout: the run did not finish in the expected number of cycles");
  end

  initial begin
    void'($urandom(SEED));
    reset_i      = 1'b1;
    req_valid_i  = 1'b0;
    req_op_i     = OP_VADD;
    req_vd_i     = '0;
    req_vs1_i    = '0;
    req_vs2_i    = '0;
    req_scalar_i = '0;
    req_vl_i     = '0;
    resp_ready_i = 1'b0;
    req_count    = 0;
    resp_count   = 0;
    model_reset();
    repeat (4) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check_value("resp_valid_o", 32'd0, 32'(resp_valid_o));
    check_value("req_ready_o", 32'd1, 32'(req_ready_o));
    @(posedge clk_i);
    fork
      toggle_resp_ready();
    join_none
    run_reset_sweep();
    run_random_ops();
    do begin
      @(negedge clk_i);
    end while (resp_count != req_count);
    // Any later response has no request behind it
    repeat (DRAIN_CYCLES) @(negedge clk_i);
    if (resp_valid_o) begin
      abort_run("A response was still pending after every request had been answered");
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

endmodule : tb_ara

// ==== design/ara.sv ====
// Vector coprocessor top level
module ara import ara_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Host request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_op_e   req_op_i,
  input  vreg_idx_t req_vd_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  elen_t     req_scalar_i,
  input  vlen_t     req_vl_i,
  // Host response
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output elen_t     resp_data_o,
  output logic      resp_error_o
);

  // Dispatcher to sequencer
  logic      disp_valid;
  logic      disp_ready;
  vec_op_e   disp_op;
  vreg_idx_t disp_vd;
  vreg_idx_t disp_vs1;
  vreg_idx_t disp_vs2;
  elen_t     disp_scalar;
  vlen_t     disp_vl;
  logic      disp_skip;
  logic      retire_valid;
  logic      retire_ready;
  elen_t     retire_data;
  logic      retire_error;

  // Sequencer to lanes
  logic                issue_valid;
  vid_t                issue_id;
  vec_op_e             issue_op;
  vreg_idx_t           issue_vd;
  vreg_idx_t           issue_vs1;
  vreg_idx_t           issue_vs2;
  elen_t               issue_scalar;
  vlen_t               issue_vl;
  logic [NR_LANES-1:0] lane_ready;
  logic [NR_LANES-1:0] lane_done;
  vid_t                lane_done_id [NR_LANES];
  elen_t               lane_scalar [NR_LANES];

  ara_dispatcher i_dispatcher (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .req_valid_i   (req_valid_i ),
    .req_ready_o   (req_ready_o ),
    .req_op_i      (req_op_i    ),
    .req_vd_i      (req_vd_i    ),
    .req_vs1_i     (req_vs1_i   ),
    .req_vs2_i     (req_vs2_i   ),
    .req_scalar_i  (req_scalar_i),
    .req_vl_i      (req_vl_i    ),
    .resp_valid_o  (resp_valid_o),
    .resp_ready_i  (resp_ready_i),
    .resp_data_o   (resp_data_o ),
    .resp_error_o  (resp_error_o),
    .disp_valid_o  (disp_valid  ),
    .disp_ready_i  (disp_ready  ),
    .disp_op_o     (disp_op     ),
    .disp_vd_o     (disp_vd     ),
    .disp_vs1_o    (disp_vs1    ),
    .disp_vs2_o    (disp_vs2    ),
    .disp_scalar_o (disp_scalar ),
    .disp_vl_o     (disp_vl     ),
    .disp_skip_o   (disp_skip   ),
    .retire_valid_i(retire_valid),
    .retire_ready_o(retire_ready),
    .retire_data_i (retire_data ),
    .retire_error_i(retire_error)
  );

  ara_sequencer i_sequencer (
    .clk_i         (clk_i       ),
    .reset_i       (reset_i     ),
    .disp_valid_i  (disp_valid  ),
    .disp_ready_o  (disp_ready  ),
    .disp_op_i     (disp_op     ),
    .disp_vd_i     (disp_vd     ),
    .disp_vs1_i    (disp_vs1    ),
    .disp_vs2_i    (disp_vs2    ),
    .disp_scalar_i (disp_scalar ),
    .disp_vl_i     (disp_vl     ),
    .disp_skip_i   (disp_skip   ),
    .issue_valid_o (issue_valid ),
    .issue_id_o    (issue_id    ),
    .issue_op_o    (issue_op    ),
    .issue_vd_o    (issue_vd    ),
    .issue_vs1_o   (issue_vs1   ),
    .issue_vs2_o   (issue_vs2   ),
    .issue_scalar_o(issue_scalar),
    .issue_vl_o    (issue_vl    ),
    .lane_ready_i  (lane_ready  ),
    .lane_done_i   (lane_done   ),
    .lane_done_id_i(lane_done_id),
    .lane_scalar_i (lane_scalar ),
    .retire_valid_o(retire_valid),
    .retire_ready_i(retire_ready),
    .retire_data_o (retire_data ),
    .retire_error_o(retire_error)
  );

  // One lane per slice of the register file
  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    lane #(
      .LANE_ID(l)
    ) i_lane (
      .clk_i         (clk_i          ),
      .reset_i       (reset_i        ),
      .issue_valid_i (issue_valid    ),
      .issue_id_i    (issue_id       ),
      .issue_op_i    (issue_op       ),
      .issue_vd_i    (issue_vd       ),
      .issue_vs1_i   (issue_vs1      ),
      .issue_vs2_i   (issue_vs2      ),
      .issue_scalar_i(issue_scalar   ),
      .issue_vl_i    (issue_vl       ),
      .lane_ready_o  (lane_ready[l]  ),
      .done_o        (lane_done[l]   ),
      .done_id_o     (lane_done_id[l]),
      .scalar_o      (lane_scalar[l] )
    );
  end : gen_lanes

endmodule : ara

// ==== design/ara_sequencer.sv ====
// In-order issue and retirement
module ara_sequencer import ara_pkg::*; (
  input  logic                clk_i,
  input  logic                reset_i,
  // From the dispatcher
  input  logic                disp_valid_i,
  output logic                disp_ready_o,
  input  vec_op_e             disp_op_i,
  input  vreg_idx_t           disp_vd_i,
  input  vreg_idx_t           disp_vs1_i,
  input  vreg_idx_t           disp_vs2_i,
  input  elen_t               disp_scalar_i,
  input  vlen_t               disp_vl_i,
  input  logic                disp_skip_i,
  // Broadcast to the lanes
  output logic                issue_valid_o,
  output vid_t                issue_id_o,
  output vec_op_e             issue_op_o,
  output vreg_idx_t           issue_vd_o,
  output vreg_idx_t           issue_vs1_o,
  output vreg_idx_t           issue_vs2_o,
  output elen_t               issue_scalar_o,
  output vlen_t               issue_vl_o,
  input  logic [NR_LANES-1:0] lane_ready_i,
  // Completion from the lanes
  input  logic [NR_LANES-1:0] lane_done_i,
  input  vid_t                lane_done_id_i [NR_LANES],
  input  elen_t               lane_scalar_i [NR_LANES],
  // Retirement towards the dispatcher
  output logic                retire_valid_o,
  input  logic                retire_ready_i,
  output elen_t               retire_data_o,
  output logic                retire_error_o
);

  // ID pool and per-ID bookkeeping
  logic [NR_VINSN-1:0]   free_q;
  logic [NR_LANES-1:0]   done_q [NR_VINSN];
  logic                  err_q [NR_VINSN];
  elen_t                 scalar_q [NR_VINSN];
  logic [LANE_IDX_W-1:0] owner_q [NR_VINSN];
  // Program order of the IDs in flight
  vid_t                  order_q [NR_VINSN];
  vid_t                  wr_ptr_q;
  vid_t                  rd_ptr_q;

  vid_t alloc_id;
  vid_t head_id;
  logic accept;
  logic retire;

  //////////////////////////////////////////////////
  // Allocation and issue
  //////////////////////////////////////////////////

  // Lowest free ID wins
  always_comb begin
    alloc_id = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_id = vid_t'(i);
      end
    end
  end

  assign disp_ready_o = (|free_q) && (&lane_ready_i);
  assign accept       = disp_valid_i && disp_ready_o;

  assign issue_valid_o  = accept && !disp_skip_i;
  assign issue_id_o     = alloc_id;
  assign issue_op_o     = disp_op_i;
  assign issue_vd_o     = disp_vd_i;
  assign issue_vs1_o    = disp_vs1_i;
  assign issue_vs2_o    = disp_vs2_i;
  assign issue_scalar_o = disp_scalar_i;
  assign issue_vl_o     = disp_vl_i;

  //////////////////////////////////////////////////
  // Retirement
  //////////////////////////////////////////////////

  // Queue is empty exactly when every ID is free
  assign head_id        = order_q[rd_ptr_q];
  assign retire_valid_o = !(&free_q) && (&done_q[head_id]);
  assign retire_data_o  = scalar_q[head_id];
  assign retire_error_o = err_q[head_id];
  assign retire         = retire_valid_o && retire_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      free_q   <= '1;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      for (int i = 0; i < NR_VINSN; i++) begin
        done_q[i] <= '0;
      end
    end else begin
      if (accept) begin
        free_q[alloc_id] <= 1'b0;
        // Skipped instructions complete on acceptance
        done_q[alloc_id] <= {NR_LANES{disp_skip_i}};
        wr_ptr_q         <= wr_ptr_q + 1'b1;
      end
      for (int l = 0; l < NR_LANES; l++) begin
        if (lane_done_i[l]) begin
          done_q[lane_done_id_i[l]][l] <= 1'b1;
        end
      end
      if (retire) begin
        free_q[head_id] <= 1'b1;
        rd_ptr_q        <= rd_ptr_q + 1'b1;
      end
    end
  end

  // Result and order bookkeeping
  always_ff @(posedge clk_i) begin
    if (accept) begin
      order_q[wr_ptr_q]  <= alloc_id;
      // A skip with a nonzero vl was an illegal request
      err_q[alloc_id]    <= disp_skip_i && (disp_vl_i != '0);
      scalar_q[alloc_id] <= '0;
      owner_q[alloc_id]  <= disp_scalar_i[LANE_IDX_W-1:0];
    end
    // Only the lane holding the extracted element fills the slot
    for (int l = 0; l < NR_LANES; l++) begin
      if (lane_done_i[l] && (owner_q[lane_done_id_i[l]] == LANE_IDX_W'(l))) begin
        scalar_q[lane_done_id_i[l]] <= lane_scalar_i[l];
      end
    end
  end

endmodule : ara_sequencer

// ==== design/ara_dispatcher.sv ====
// Request checker and response slot
module ara_dispatcher import ara_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Host request
  input  logic      req_valid_i,
  output logic      req_ready_o,
  input  vec_op_e   req_op_i,
  input  vreg_idx_t req_vd_i,
  input  vreg_idx_t req_vs1_i,
  input  vreg_idx_t req_vs2_i,
  input  elen_t     req_scalar_i,
  input  vlen_t     req_vl_i,
  // Host response
  output logic      resp_valid_o,
  input  logic      resp_ready_i,
  output elen_t     resp_data_o,
  output logic      resp_error_o,
  // Towards the sequencer
  output logic      disp_valid_o,
  input  logic      disp_ready_i,
  output vec_op_e   disp_op_o,
  output vreg_idx_t disp_vd_o,
  output vreg_idx_t disp_vs1_o,
  output vreg_idx_t disp_vs2_o,
  output elen_t     disp_scalar_o,
  output vlen_t     disp_vl_o,
  output logic      disp_skip_o,
  // Retirement from the sequencer
  input  logic      retire_valid_i,
  output logic      retire_ready_o,
  input  elen_t     retire_data_i,
  input  logic      retire_error_i
);

  logic  is_ext;
  logic  illegal;
  logic  vl_zero;
  logic  resp_valid_q;
  elen_t resp_data_q;
  logic  resp_error_q;

  //////////////////////////////////////////////////
  // Decode
  //////////////////////////////////////////////////

  // Extract ignores vl, its scalar is the element index
  assign is_ext  = (req_op_i == OP_VEXT_XV);
  assign illegal = !is_ext && (req_vl_i > vlen_t'(VLMAX));
  assign vl_zero = !is_ext && (req_vl_i == '0);

  assign disp_valid_o  = req_valid_i;
  assign req_ready_o   = disp_ready_i;
  assign disp_op_o     = req_op_i;
  assign disp_vd_o     = req_vd_i;
  assign disp_vs1_o    = req_vs1_i;
  assign disp_vs2_o    = req_vs2_i;
  assign disp_scalar_o = req_scalar_i;
  assign disp_vl_o     = req_vl_i;
  // Lanes never see these
  assign disp_skip_o   = illegal | vl_zero;

  //////////////////////////////////////////////////
  // Response slot
  //////////////////////////////////////////////////

  assign retire_ready_o = !resp_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else if (retire_valid_i && retire_ready_o) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_valid_i && retire_ready_o) begin
      resp_data_q  <= retire_data_i;
      resp_error_q <= retire_error_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = resp_data_q;
  assign resp_error_o = resp_error_q;

endmodule : ara_dispatcher

// ==== design/lane.sv ====
// Vector lane with instruction queue and ALU
module lane import ara_pkg::*; #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // Broadcast from the sequencer
  input  logic      issue_valid_i,
  input  vid_t      issue_id_i,
  input  vec_op_e   issue_op_i,
  input  vreg_idx_t issue_vd_i,
  input  vreg_idx_t issue_vs1_i,
  input  vreg_idx_t issue_vs2_i,
  input  elen_t     issue_scalar_i,
  input  vlen_t     issue_vl_i,
  output logic      lane_ready_o,
  // Completion
  output logic      done_o,
  output vid_t      done_id_o,
  output elen_t     scalar_o
);

  typedef enum logic {IDLE, RUN} state_e;

  // Instruction queue
  vid_t              q_id [LANE_QUEUE_DEPTH];
  vec_op_e           q_op [LANE_QUEUE_DEPTH];
  vreg_idx_t         q_vd [LANE_QUEUE_DEPTH];
  vreg_idx_t         q_vs1 [LANE_QUEUE_DEPTH];
  vreg_idx_t         q_vs2 [LANE_QUEUE_DEPTH];
  elen_t             q_scalar [LANE_QUEUE_DEPTH];
  vlen_t             q_vl [LANE_QUEUE_DEPTH];
  logic [LQ_PTR_W-1:0] q_wr_q;
  logic [LQ_PTR_W-1:0] q_rd_q;
  logic [LQ_PTR_W:0]   q_cnt_q;
  logic              push;
  logic              pop;

  // Instruction in execution
  state_e    state_q;
  vid_t      cur_id_q;
  vec_op_e   cur_op_q;
  vreg_idx_t cur_vd_q;
  vreg_idx_t cur_vs1_q;
  vreg_idx_t cur_vs2_q;
  elen_t     cur_scalar_q;
  vlen_t     cur_vl_q;
  slot_t     slot_q;

  vlen_t elem_idx;
  logic  is_ext;
  logic  active;
  logic  last;
  logic  owns_idx;
  slot_t rd_slot;
  elen_t a_data;
  elen_t b_data;
  elen_t result;
  logic  done_q;
  vid_t  done_id_q;
  elen_t scalar_q;

  //////////////////////////////////////////////////
  // Queue
  //////////////////////////////////////////////////

  assign lane_ready_o = (q_cnt_q < (LQ_PTR_W + 1)'(LANE_QUEUE_DEPTH));
  assign push         = issue_valid_i && lane_ready_o;
  assign pop          = (state_q == IDLE) && (q_cnt_q != '0);

  //////////////////////////////////////////////////
  // Element loop
  //////////////////////////////////////////////////

  // Slot s of this lane holds element s * NR_LANES + LANE_ID
  assign elem_idx = vlen_t'(slot_q) * vlen_t'(NR_LANES) + vlen_t'(LANE_ID);
  assign is_ext   = (cur_op_q == OP_VEXT_XV);
  assign active   = !is_ext && (elem_idx < cur_vl_q);
  assign last     = is_ext || !active || (slot_q == slot_t'(ELEMS_PER_LANE - 1)) ||
                    ((elem_idx + vlen_t'(NR_LANES)) >= cur_vl_q);

  // Extract index ownership
  assign owns_idx = (cur_scalar_q[LANE_IDX_W-1:0] == LANE_IDX_W'(LANE_ID)) &&
                    (cur_scalar_q < elen_t'(VLMAX));
  assign rd_slot  = is_ext ? cur_scalar_q[LANE_IDX_W +: SLOT_W] : slot_q;

  always_comb begin
    case (cur_op_q)
      OP_VADD:    result = a_data + b_data;
      OP_VSUB:    result = a_data - b_data;
      OP_VAND:    result = a_data & b_data;
      OP_VOR:     result = a_data | b_data;
      OP_VXOR:    result = a_data ^ b_data;
      OP_VADD_VX: result = a_data + cur_scalar_q;
      OP_VMV_VX:  result = cur_scalar_q;
      default:    result = '0;
    endcase
  end

  lane_vrf i_vrf (
    .clk_i      (clk_i                      ),
    .reset_i    (reset_i                    ),
    .rd_a_reg_i (cur_vs2_q                  ),
    .rd_b_reg_i (cur_vs1_q                  ),
    .rd_slot_i  (rd_slot                    ),
    .rd_a_data_o(a_data                     ),
    .rd_b_data_o(b_data                     ),
    .wr_en_i    ((state_q == RUN) && active ),
    .wr_reg_i   (cur_vd_q                   ),
    .wr_slot_i  (slot_q                     ),
    .wr_data_i  (result                     )
  );

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
      q_wr_q  <= '0;
      q_rd_q  <= '0;
      q_cnt_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (push) begin
        q_wr_q <= q_wr_q + 1'b1;
      end
      if (pop) begin
        q_rd_q <= q_rd_q + 1'b1;
      end
      q_cnt_q <= q_cnt_q + {{LQ_PTR_W{1'b0}}, push} - {{LQ_PTR_W{1'b0}}, pop};
      case (state_q)
        IDLE: begin
          if (pop) begin
            state_q <= RUN;
          end
        end
        RUN: begin
          if (last) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      q_id[q_wr_q]     <= issue_id_i;
      q_op[q_wr_q]     <= issue_op_i;
      q_vd[q_wr_q]     <= issue_vd_i;
      q_vs1[q_wr_q]    <= issue_vs1_i;
      q_vs2[q_wr_q]    <= issue_vs2_i;
      q_scalar[q_wr_q] <= issue_scalar_i;
      q_vl[q_wr_q]     <= issue_vl_i;
    end
    if (pop) begin
      cur_id_q     <= q_id[q_rd_q];
      cur_op_q     <= q_op[q_rd_q];
      cur_vd_q     <= q_vd[q_rd_q];
      cur_vs1_q    <= q_vs1[q_rd_q];
      cur_vs2_q    <= q_vs2[q_rd_q];
      cur_scalar_q <= q_scalar[q_rd_q];
      cur_vl_q     <= q_vl[q_rd_q];
      slot_q       <= '0;
    end else if (state_q == RUN) begin
      slot_q <= slot_q + 1'b1;
    end
    if ((state_q == RUN) && last) begin
      done_id_q <= cur_id_q;
      scalar_q  <= (is_ext && owns_idx) ? a_data : '0;
    end
  end

  assign done_o    = done_q;
  assign done_id_o = done_id_q;
  assign scalar_o  = scalar_q;

endmodule : lane

// ==== design/lane_vrf.sv ====
// Per-lane vector register slice
module lane_vrf import ara_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  // Read ports share one slot
  input  vreg_idx_t rd_a_reg_i,
  input  vreg_idx_t rd_b_reg_i,
  input  slot_t     rd_slot_i,
  output elen_t     rd_a_data_o,
  output elen_t     rd_b_data_o,
  // Write port
  input  logic      wr_en_i,
  input  vreg_idx_t wr_reg_i,
  input  slot_t     wr_slot_i,
  input  elen_t     wr_data_i
);

  elen_t mem_q [NR_VREGS][ELEMS_PER_LANE];

  assign rd_a_data_o = mem_q[rd_a_reg_i][rd_slot_i];
  assign rd_b_data_o = mem_q[rd_b_reg_i][rd_slot_i];

  // Registers start out zero
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int r = 0; r < NR_VREGS; r++) begin
        for (int s = 0; s < ELEMS_PER_LANE; s++) begin
          mem_q[r][s] <= '0;
        end
      end
    end else if (wr_en_i) begin
      mem_q[wr_reg_i][wr_slot_i] <= wr_data_i;
    end
  end

endmodule : lane_vrf

// ==== design/ara_pkg.sv ====
// Vector coprocessor shared definitions
package ara_pkg;

  //////////////////////////////////////////////////
  // Machine sizes
  //////////////////////////////////////////////////

  localparam int unsigned NR_LANES = 4;
  localparam int unsigned ELEN = 32;
  localparam int unsigned VLEN = 512;
  localparam int unsigned VLMAX = VLEN / ELEN;
  localparam int unsigned ELEMS_PER_LANE = VLMAX / NR_LANES;
  localparam int unsigned NR_VREGS = 8;

  // Instructions in flight and per-lane buffering
  localparam int unsigned NR_VINSN = 4;
  localparam int unsigned LANE_QUEUE_DEPTH = 2;

  //////////////////////////////////////////////////
  // Derived widths
  //////////////////////////////////////////////////

  localparam int unsigned LANE_IDX_W = $clog2(NR_LANES);
  localparam int unsigned SLOT_W = $clog2(ELEMS_PER_LANE);
  localparam int unsigned VREG_IDX_W = $clog2(NR_VREGS);
  localparam int unsigned VL_W = $clog2(VLMAX + 1);
  localparam int unsigned VID_W = $clog2(NR_VINSN);
  localparam int unsigned LQ_PTR_W = $clog2(LANE_QUEUE_DEPTH);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [ELEN-1:0] elen_t;
  typedef logic [VREG_IDX_W-1:0] vreg_idx_t;
  // Holds 0..VLMAX inclusive
  typedef logic [VL_W-1:0] vlen_t;
  typedef logic [VID_W-1:0] vid_t;
  typedef logic [SLOT_W-1:0] slot_t;

  // Supported vector operations
  typedef enum logic [2:0] {
    OP_VADD    = 3'd0,
    OP_VSUB    = 3'd1,
    OP_VAND    = 3'd2,
    OP_VOR     = 3'd3,
    OP_VXOR    = 3'd4,
    OP_VADD_VX = 3'd5,
    OP_VMV_VX  = 3'd6,
    OP_VEXT_XV = 3'd7
  } vec_op_e;

endpackage : ara_pkg
